/* verilog.f */
src/cpu_pkg.sv
src/cpu_loader.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_memory.sv
src/cpu_top.sv
testbench/cpu_assertions.sv
testbench/tb_cpu.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_cpu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* testbench/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

    localparam int    NTESTS    = 6;
    localparam addr_t HOST_BASE = 16'h9000;
    localparam int    PRE_LEN   = 15;   // ADDI r1..r15
    localparam int    POST_LEN  = 17;   // 16 register stores and HALT
    localparam int    BODY_LEN [NTESTS] = '{40, 30, 40, 48, 40, 20};

    logic  clk = 1'b0;
    logic  rst_n;
    logic  host_in_valid;
    word_t host_in_data;
    logic  host_in_last;
    logic  host_in_ready;
    logic  host_out_valid;
    addr_t host_out_addr;
    word_t host_out_data;
    logic  host_out_ready;
    logic  halted;

    integer seed = 25;
    word_t  prog [$];
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    string  test_name = "";
    logic   checking = 1'b0;
    logic   bp_mode = 1'b0;    // random back-pressure on the host store port
    int     low_cnt = 0;
    int     test_errs = 0;
    int     stores_seen = 0;
    int     tests_failed = 0;
    int     total_errs = 0;

    always #4 clk = ~clk;

    cpu_top #(
        .IM_DEPTH(256),
        .DM_DEPTH(256),
        .HOST_BASE(HOST_BASE)
    ) dut (
        .clk, .rst_n, .host_in_valid, .host_in_data, .host_in_last, .host_in_ready,
        .host_out_valid, .host_out_addr, .host_out_data, .host_out_ready, .halted
    );

    ////////////////////
    // program generation
    ////////////////////
    function automatic int pick(int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic word_t alu_word(opcode_t op, int rd, int rs, int rt);
        return (word_t'(op) << OP_LSB) | (word_t'(rd) << RD_LSB) | (word_t'(rs) << RS_LSB) |
               (word_t'(rt) << RT_LSB);
    endfunction

    function automatic word_t imm_word(opcode_t op, int rd, int rs, int imm);
        return (word_t'(op) << OP_LSB) | (word_t'(rd) << RD_LSB) | (word_t'(rs) << RS_LSB) |
               word_t'(imm & 'hffff);
    endfunction

    function automatic word_t random_alu(int rd, int rs);
        case (pick(6))
            0:       return alu_word(ADD, rd, rs, pick(16));
            1:       return alu_word(SUB, rd, rs, pick(16));
            2:       return alu_word(AND, rd, rs, pick(16));
            3:       return alu_word(OR, rd, rs, pick(16));
            4:       return alu_word(XOR, rd, rs, pick(16));
            default: return imm_word(ADDI, rd, rs, pick(65536));
        endcase
    endfunction

    function automatic word_t random_branch(int target);
        case (pick(4))
            0:       return imm_word(BEQ, 0, 0, target);
            1:       return imm_word(BNE, 0, 0, target);
            2:       return imm_word(BLT, 0, 0, target);
            default: return imm_word(JMP, 0, 0, target);
        endcase
    endfunction

    task automatic build_program(int kind);
        int          body_end;
        int          last_rd;
        int          sel;
        int          rd;
        int          rs;
        int          a;
        logic [15:0] stored;  // data addresses written so far
        prog.delete();
        stored  = '0;
        last_rd = 1;
        for (int r = 1; r < 16; r++) begin
            prog.push_back(imm_word(ADDI, r, 0, pick(65536)));
        end
        body_end = prog.size() + BODY_LEN[kind];
        while (prog.size() < body_end) begin
            rd  = 1 + pick(15);
            rs  = pick(16);
            sel = pick(10);
            if (kind == 1) begin
                prog.push_back(random_alu(rd, last_rd)); // reads the previous result
                last_rd = rd;
            end else if (kind == 2 && sel < 3) begin
                a = pick(16);
                prog.push_back(imm_word(ST, rs, 0, a));
                stored[a] = 1'b1;
                if (sel == 0) begin
                    prog.push_back(imm_word(LD, rd, 0, a)); // load right behind the store
                end
            end else if (kind == 2 && sel < 6 && stored != '0) begin
                a = pick(16);
                while (!stored[a]) begin
                    a = (a + 1) % 16;
                end
                prog.push_back(imm_word(LD, rd, 0, a));
            end else if ((kind == 3 || kind == 4) && sel < 3) begin
                a = prog.size() + 1 + pick(4);  // forward only
                if (a > body_end) begin
                    a = body_end;
                end
                prog.push_back(random_branch(a));
            end else if (kind == 4 && sel < 5) begin
                prog.push_back(imm_word(ST, rs, 0, HOST_BASE + 16 + pick(16)));
            end else begin
                prog.push_back(random_alu(rd, rs));
            end
        end
        for (int r = 0; r < 16; r++) begin
            prog.push_back(imm_word(ST, r, 0, HOST_BASE + r));
        end
        prog.push_back(word_t'(HALT) << OP_LSB);
    endtask

    ////////////////////
    // reference model
    ////////////////////
    task automatic predict_stores();
        word_t   regs [16];
        word_t   dm [256];
        logic    z;
        logic    n;
        int      pc;
        int      rd;
        word_t   w;
        opcode_t op;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   res;
        addr_t   addr;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        z  = 1'b0;
        n  = 1'b0;
        pc = 0;
        while (pc < prog.size()) begin
            w    = prog[pc];
            op   = opcode_t'(w[31:24]);
            rd   = int'(w[23:20]);
            a    = regs[w[19:16]];
            b    = regs[w[15:12]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = a[15:0] + imm[15:0];
            res  = '0;
            pc   = pc + 1;
            case (op)
                ADD:  res = a + b;
                SUB:  res = a - b;
                AND:  res = a & b;
                OR:   res = a | b;
                XOR:  res = a ^ b;
                ADDI: res = a + imm;
                LD:   regs[rd] = dm[addr[7:0]];
                ST: begin
                    if (addr >= HOST_BASE) begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(regs[rd]);
                    end else begin
                        dm[addr[7:0]] = regs[rd];
                    end
                end
                BEQ, BNE, BLT, JMP: begin
                    if ((op == JMP) || (op == BEQ && z) || (op == BNE && !z) ||
                        (op == BLT && n)) begin
                        pc = int'(imm[15:0]);
                    end
                end
                HALT:    pc = prog.size();
                default: ;
            endcase
            if (op inside {ADD, SUB, AND, OR, XOR, ADDI}) begin
                regs[rd] = res;
                z        = (res == '0);
                n        = res[31];
            end
            regs[0] = '0;
        end
    endtask

    ////////////////////
    // host side
    ////////////////////
    task automatic load_program(logic gaps);
        for (int i = 0; i < prog.size(); i++) begin
            if (gaps) begin
                repeat (pick(3)) begin
                    host_in_valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
            end
            host_in_valid = 1'b1;
            host_in_data  = prog[i];
            host_in_last  = (i == prog.size() - 1);
            while (!host_in_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
        end
        host_in_valid = 1'b0;
        host_in_last  = 1'b0;
    endtask

    always begin
        @(posedge clk);
        #1;
        if (!bp_mode) begin
            host_out_ready = 1'b1;
        end else if (low_cnt > 0) begin
            host_out_ready = 1'b0;
            low_cnt--;
        end else begin
            host_out_ready = 1'b1;
            if (pick(3) == 0) begin
                low_cnt = pick(6); // stall 0 to 5 cycles
            end
        end
    end

    // store monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (checking && host_out_valid && host_out_ready) begin
            stores_seen++;
            if (halted) begin
                $display("%s: host store to %h after halt", test_name, host_out_addr);
                test_errs++;
            end else if (exp_addr.size() == 0) begin
                $display("%s: extra host store to %h, none expected", test_name, host_out_addr);
                test_errs++;
            end else begin
                if ((host_out_addr !== exp_addr[0]) || (host_out_data !== exp_data[0])) begin
                    $display("** Error %s: store %0d expected %h @ %h, actual %h @ %h",
                             test_name, stores_seen, exp_data[0], exp_addr[0],
                             host_out_data, host_out_addr);
                    test_errs++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic check_program(int kind, string name);
        test_name   = name;
        test_errs   = 0;
        stores_seen = 0;
        bp_mode     = (kind == 4);
        low_cnt     = 0;
        build_program(kind);
        predict_stores();
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
        end
        #1;
        rst_n    = 1'b1;
        checking = 1'b1;
        load_program(kind == 0);
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        repeat (50) begin // quiet window after halt
            @(posedge clk);
        end
        #1;
        checking = 1'b0;
        if (exp_addr.size() != 0) begin
            $display("%s: %0d expected host stores never arrived", name, exp_addr.size());
            test_errs++;
        end
        if (test_errs == 0) begin
            $display("test %s: ok, %0d words, %0d host stores", name, prog.size(), stores_seen);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
    endtask

    initial begin
        int limit;
        limit = 0;
        for (int k = 0; k < NTESTS; k++) begin
            limit += 20 * (PRE_LEN + BODY_LEN[k] + 1 + POST_LEN) + 2000;
        end
        repeat (limit) begin
            @(posedge clk);
        end
        $display("timeout in test %s: halted never rose within %0d cycles", test_name, limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        host_in_valid  = 1'b0;
        host_in_data   = '0;
        host_in_last   = 1'b0;
        host_out_ready = 1'b1;
        check_program(0, "load_alu");
        check_program(1, "hazards");
        check_program(2, "data_memory");
        check_program(3, "branches");
        check_program(4, "back_pressure");
        check_program(5, "halt");
        $display("%0d tests, %0d failed, %0d errors", NTESTS, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/cpu_assertions.sv */
`timescale 1ns/10ps

module cpu_assertions import cpu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  host_in_ready,
    input logic  host_out_valid,
    input addr_t host_out_addr,
    input word_t host_out_data,
    input logic  host_out_ready,
    input logic  halted
);

    // a waiting host store keeps address and data
    store_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_out_valid && !host_out_ready |=>
            host_out_valid && $stable(host_out_addr) && $stable(host_out_data))
        else $error("host store changed while ready was low");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted fell without reset");

    no_store_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_out_valid && host_in_ready))
        else $error("host store during program load");

    load_closed_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !host_in_ready)
        else $error("host_in_ready high after halt");

endmodule

bind cpu_top cpu_assertions u_checks (
    .clk, .rst_n, .host_in_ready, .host_out_valid, .host_out_addr, .host_out_data,
    .host_out_ready, .halted
);

/* src/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
    parameter int    IM_DEPTH  = 256,
    parameter int    DM_DEPTH  = 256,
    parameter addr_t HOST_BASE = 16'h9000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  host_in_valid,
    input  word_t host_in_data,
    input  logic  host_in_last,
    output logic  host_in_ready,
    output logic  host_out_valid,
    output addr_t host_out_addr,
    output word_t host_out_data,
    input  logic  host_out_ready,
    output logic  halted
);

    logic     run;
    logic     im_wr_en;
    addr_t    im_wr_addr;
    word_t    im_wr_data;
    word_t    if_instr;
    logic     hazard_stall;
    logic     hold;
    logic     halt_seen;
    logic     branch_taken;
    addr_t    branch_target;
    opcode_t  ex_op;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    reg_idx_t ex_rd;
    logic     ex_wr_en;
    opcode_t  mem_op;
    word_t    mem_addr_or_result;
    word_t    mem_store_data;
    reg_idx_t mem_rd;
    logic     mem_wr_en;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    cpu_loader #(.IM_DEPTH(IM_DEPTH)) u_loader (
        .clk, .rst_n, .host_in_valid, .host_in_data, .host_in_last, .host_in_ready,
        .halt_seen, .run, .halted, .im_wr_en, .im_wr_addr, .im_wr_data
    );

    // if_pc left open, only useful for probing
    cpu_fetch #(.IM_DEPTH(IM_DEPTH)) u_fetch (
        .clk, .rst_n, .run, .im_wr_en, .im_wr_addr, .im_wr_data, .hazard_stall, .hold,
        .branch_taken, .branch_target, .if_instr, .if_pc()
    );

    // pending destinations are the ID/EX and EX/MEM registers
    cpu_decode u_decode (
        .clk, .rst_n, .if_instr, .hazard_stall, .hold, .branch_taken, .wb_en, .wb_reg,
        .wb_data, .ex_op, .ex_a, .ex_b, .ex_imm, .ex_rd, .ex_wr_en,
        .pend_ex_rd(ex_rd), .pend_ex_wr(ex_wr_en), .pend_mem_rd(mem_rd),
        .pend_mem_wr(mem_wr_en)
    );

    cpu_execute u_execute (
        .clk, .rst_n, .hold, .ex_op, .ex_a, .ex_b, .ex_imm, .ex_rd, .ex_wr_en,
        .branch_taken, .branch_target, .mem_op, .mem_addr_or_result, .mem_store_data,
        .mem_rd, .mem_wr_en
    );

    cpu_memory #(.DM_DEPTH(DM_DEPTH), .HOST_BASE(HOST_BASE)) u_memory (
        .clk, .rst_n, .mem_op, .mem_addr_or_result, .mem_store_data, .mem_rd, .mem_wr_en,
        .hold, .halt_seen, .host_out_valid, .host_out_addr, .host_out_data,
        .host_out_ready, .wb_en, .wb_reg, .wb_data
    );

endmodule

/* src/cpu_memory.sv */
`timescale 1ns/10ps

module cpu_memory import cpu_pkg::*; #(
    parameter int    DM_DEPTH  = 256,
    parameter addr_t HOST_BASE = 16'h9000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  opcode_t  mem_op,
    input  word_t    mem_addr_or_result,
    input  word_t    mem_store_data,
    input  reg_idx_t mem_rd,
    input  logic     mem_wr_en,
    output logic     hold,
    output logic     halt_seen,
    output logic     host_out_valid,
    output addr_t    host_out_addr,
    output word_t    host_out_data,
    input  logic     host_out_ready,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    localparam int DM_AW = $clog2(DM_DEPTH);

    word_t            dm [DM_DEPTH];
    addr_t            addr;
    logic [DM_AW-1:0] dm_idx;
    logic             is_host;

    assign addr    = mem_addr_or_result[ADDR_W-1:0];
    assign dm_idx  = addr[DM_AW-1:0]; // wraps modulo DM_DEPTH
    assign is_host = (addr >= HOST_BASE);

    ////////////////////
    // host store port
    ////////////////////
    assign host_out_valid = (mem_op == ST) && is_host;
    assign host_out_addr  = addr;
    assign host_out_data  = mem_store_data;
    assign hold           = host_out_valid && !host_out_ready; // freezes every stage

    assign halt_seen = (mem_op == HALT);

    always_ff @(posedge clk) begin
        if ((mem_op == ST) && !is_host) begin
            dm[dm_idx] <= mem_store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else if (!hold) begin
            wb_en <= mem_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_reg  <= mem_rd;
            wb_data <= (mem_op == LD) ? dm[dm_idx] : mem_addr_or_result;
        end
    end

endmodule

/* src/cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  opcode_t  ex_op,
    input  word_t    ex_a,
    input  word_t    ex_b,
    input  word_t    ex_imm,
    input  reg_idx_t ex_rd,
    input  logic     ex_wr_en,
    output logic     branch_taken,
    output addr_t    branch_target,
    output opcode_t  mem_op,
    output word_t    mem_addr_or_result,
    output word_t    mem_store_data,
    output reg_idx_t mem_rd,
    output logic     mem_wr_en
);

    word_t alu_res;
    logic  set_flags;
    logic  z_flag;
    logic  n_flag;

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        alu_res   = '0;
        set_flags = 1'b0;
        case (ex_op)
            ADD: begin
                alu_res   = ex_a + ex_b;
                set_flags = 1'b1;
            end
            SUB: begin
                alu_res   = ex_a - ex_b;
                set_flags = 1'b1;
            end
            AND: begin
                alu_res   = ex_a & ex_b;
                set_flags = 1'b1;
            end
            OR: begin
                alu_res   = ex_a | ex_b;
                set_flags = 1'b1;
            end
            XOR: begin
                alu_res   = ex_a ^ ex_b;
                set_flags = 1'b1;
            end
            ADDI: begin
                alu_res   = ex_a + ex_imm;
                set_flags = 1'b1; // counts as an ALU op for flags
            end
            LD, ST:  alu_res = ex_a + ex_imm; // address only, flags untouched
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            z_flag <= 1'b0;
            n_flag <= 1'b0;
        end else if (!hold && set_flags) begin
            z_flag <= (alu_res == '0);
            n_flag <= alu_res[WORD_W-1];
        end
    end

    // branch resolves here, fetch and decode flush on taken
    assign branch_taken  = ((ex_op == BEQ) && z_flag) ||
                           ((ex_op == BNE) && !z_flag) ||
                           ((ex_op == BLT) && n_flag) ||
                           (ex_op == JMP);
    assign branch_target = ex_imm[ADDR_W-1:0];

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_op    <= NOP;
            mem_wr_en <= 1'b0;
        end else if (!hold) begin
            mem_op    <= ex_op;
            mem_wr_en <= ex_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_addr_or_result <= alu_res;
            mem_store_data     <= ex_b;
            mem_rd             <= ex_rd;
        end
    end

endmodule

/* src/cpu_decode.sv */
`timescale 1ns/10ps

module cpu_decode import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    if_instr,
    output logic     hazard_stall,
    input  logic     hold,
    input  logic     branch_taken,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    output opcode_t  ex_op,
    output word_t    ex_a,
    output word_t    ex_b,
    output word_t    ex_imm,
    output reg_idx_t ex_rd,
    output logic     ex_wr_en,
    input  reg_idx_t pend_ex_rd,
    input  logic     pend_ex_wr,
    input  reg_idx_t pend_mem_rd,
    input  logic     pend_mem_wr
);

    localparam int NREGS = 2 ** REG_W;

    word_t    rf [NREGS];
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t src_b;
    logic     uses_a;
    logic     uses_b;
    logic     writes;
    word_t    opnd_a;
    word_t    opnd_b;

    // r0 reads zero, writeback passes through in the same cycle
    function automatic word_t read_reg(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_en && (wb_reg == idx)) begin
            val = wb_data;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    // result still in execute or memory
    function automatic logic pending(reg_idx_t idx);
        return (pend_ex_wr && (pend_ex_rd == idx)) || (pend_mem_wr && (pend_mem_rd == idx));
    endfunction

    always_comb begin
        op     = opcode_t'(if_instr[OP_LSB +: OP_W]);
        rd     = if_instr[RD_LSB +: REG_W];
        rs     = if_instr[RS_LSB +: REG_W];
        rt     = if_instr[RT_LSB +: REG_W];
        uses_a = 1'b0;
        uses_b = 1'b0;
        writes = 1'b0;
        case (op)
            ADD, SUB, AND, OR, XOR: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
                writes = 1'b1;
            end
            ADDI, LD: begin
                uses_a = 1'b1;
                writes = 1'b1;
            end
            ST: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
            end
            default: ; // branches, NOP, HALT read nothing
        endcase
        src_b        = (op == ST) ? rd : rt; // store data comes from rd
        opnd_a       = read_reg(rs);
        opnd_b       = read_reg(src_b);
        hazard_stall = (uses_a && pending(rs)) || (uses_b && pending(src_b));
    end

    always_ff @(posedge clk) begin
        if (wb_en && (wb_reg != '0)) begin
            rf[wb_reg] <= wb_data;
        end
    end

    ////////////////////
    // ID/EX register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_op    <= NOP;
            ex_wr_en <= 1'b0;
        end else if (!hold) begin
            if (branch_taken || hazard_stall) begin
                ex_op    <= NOP; // bubble
                ex_wr_en <= 1'b0;
            end else begin
                ex_op    <= op;
                ex_wr_en <= writes && (rd != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_a   <= opnd_a;
            ex_b   <= opnd_b;
            ex_imm <= sext_imm(if_instr);
            ex_rd  <= rd;
        end
    end

endmodule

/* src/cpu_fetch.sv */
`timescale 1ns/10ps

module cpu_fetch import cpu_pkg::*; #(
    parameter int IM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  im_wr_en,
    input  addr_t im_wr_addr,
    input  word_t im_wr_data,
    input  logic  hazard_stall,
    input  logic  hold,
    input  logic  branch_taken,
    input  addr_t branch_target,
    output word_t if_instr,
    output addr_t if_pc
);

    localparam int IM_AW = $clog2(IM_DEPTH);

    word_t            im [IM_DEPTH];
    addr_t            pc;
    logic [IM_AW-1:0] rd_idx;
    word_t            rd_word;
    logic             halt_fetched; // nothing past HALT enters the pipe

    assign rd_idx  = pc[IM_AW-1:0];
    assign rd_word = im[rd_idx];

    // loader port
    always_ff @(posedge clk) begin
        if (im_wr_en) begin
            im[im_wr_addr[IM_AW-1:0]] <= im_wr_data;
        end
    end

    ////////////////////
    // pc and IF/ID register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= '0;
            if_instr     <= NOP_INSTR;
            if_pc        <= '0;
            halt_fetched <= 1'b0;
        end else if (!hold && (branch_taken || !hazard_stall)) begin
            if (branch_taken) begin
                pc           <= branch_target;
                if_instr     <= NOP_INSTR; // kill the word being fetched
                halt_fetched <= 1'b0;
            end else if (!run || halt_fetched) begin
                if_instr <= NOP_INSTR;
            end else begin
                if_instr     <= rd_word;
                if_pc        <= pc;
                pc           <= pc + 1'b1;
                halt_fetched <= (opcode_t'(rd_word[OP_LSB +: OP_W]) == HALT);
            end
        end
    end

endmodule

/* src/cpu_loader.sv */
`timescale 1ns/10ps

module cpu_loader import cpu_pkg::*; #(
    parameter int IM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  host_in_valid,
    input  word_t host_in_data,
    input  logic  host_in_last,
    output logic  host_in_ready,
    input  logic  halt_seen,
    output logic  run,
    output logic  halted,
    output logic  im_wr_en,
    output addr_t im_wr_addr,
    output word_t im_wr_data
);

    loader_state_t state;
    loader_state_t state_nxt;
    addr_t         wr_addr;
    logic          accept;

    assign host_in_ready = (state == LOAD);
    assign accept        = host_in_valid && host_in_ready;
    assign run           = (state == RUN);
    assign halted        = (state == HALTED);

    // accepted words go straight into instruction memory
    assign im_wr_en   = accept;
    assign im_wr_addr = wr_addr;
    assign im_wr_data = host_in_data;

    always_comb begin
        state_nxt = state;
        case (state)
            LOAD: begin
                if (accept && host_in_last) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (halt_seen) begin
                    state_nxt = HALTED;
                end
            end
            default: ; // HALTED is sticky until reset
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= LOAD;
            wr_addr <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                wr_addr <= (wr_addr == addr_t'(IM_DEPTH - 1)) ? '0 : wr_addr + 1'b1;
            end
        end
    end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int WORD_W = 32;
    localparam int ADDR_W = 16;
    localparam int REG_W  = 4;
    localparam int OP_W   = 8;
    localparam int IMM_W  = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t; // word address, pc and data
    typedef logic [REG_W-1:0]  reg_idx_t;

    // instruction fields
    localparam int OP_LSB = 24;
    localparam int RD_LSB = 20;
    localparam int RS_LSB = 16;
    localparam int RT_LSB = 12;

    typedef enum logic [OP_W-1:0] {
        NOP  = 8'h00,
        ADD  = 8'h01,
        SUB  = 8'h02,
        AND  = 8'h03,
        OR   = 8'h04,
        XOR  = 8'h05,
        ADDI = 8'h06,
        LD   = 8'h07,
        ST   = 8'h08,
        BEQ  = 8'h09,
        BNE  = 8'h0A,
        BLT  = 8'h0B,
        JMP  = 8'h0C,
        HALT = 8'h0F
    } opcode_t;

    localparam word_t NOP_INSTR = '0; // all-zero word decodes as NOP

    typedef enum logic [1:0] {
        LOAD,
        RUN,
        HALTED
    } loader_state_t;

    // low 16 bits, sign extended
    function automatic word_t sext_imm(word_t instr);
        return {{(WORD_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    endfunction

endpackage
